/* design/fe_pkg.sv */
// Fetch front end definitions
package fe_pkg;

  // Datapath widths
  localparam int fe_vaddr_width_lp = 32;
  localparam int fe_instr_width_lp = 32;

  // Byte distance between sequential fetches
  localparam int fe_pc_step_lp = 4;

  // Core to front end command opcodes
  typedef enum logic [1:0]
  {
    e_op_state_reset   = 2'd0
    , e_op_pc_redirect = 2'd1
    , e_op_wait        = 2'd2
  } fe_opcode_e;

  typedef struct packed
  {
    fe_opcode_e                   opcode;
    logic [fe_vaddr_width_lp-1:0] vaddr;
  } fe_cmd_s;

  // Kind of message placed in the fetch queue
  typedef enum logic
  {
    e_fe_fetch       = 1'b0
    , e_fe_exception = 1'b1
  } fe_msg_type_e;

  // Exceptions carry the faulting pc and a zero instruction
  typedef struct packed
  {
    fe_msg_type_e                 msg_type;
    logic [fe_vaddr_width_lp-1:0] pc;
    logic [fe_instr_width_lp-1:0] instr;
  } fe_queue_s;

  // Controller states
  typedef enum logic [1:0]
  {
    e_wait    = 2'd0
    , e_run   = 2'd1
    , e_stall = 2'd2
  } fe_state_e;

endpackage

/* design/fe_redirect_if.sv */
// Redirect and command bundle
interface fe_redirect_if
  import fe_pkg::*;
  ();

  // Restart fetch this cycle
  logic                         redirect_v;
  logic [fe_vaddr_width_lp-1:0] redirect_pc;

  // Decoded view of the command accepted this cycle
  logic                         cmd_v;
  logic                         cmd_immediate;
  logic                         cmd_stall;
  logic                         cmd_wait;

  logic [fe_vaddr_width_lp-1:0] resume_pc;

  modport decode (output redirect_pc, cmd_v, cmd_immediate, cmd_stall, cmd_wait, resume_pc);

  modport ctrl (output redirect_v, input cmd_v, cmd_immediate, cmd_stall, cmd_wait);

  modport pc_gen (input redirect_v, redirect_pc, cmd_v, cmd_immediate, cmd_stall, cmd_wait,
                  resume_pc);

endinterface

/* design/fe_cmd_decode.sv */
// Front end command decode
module fe_cmd_decode
  import fe_pkg::*;
  (input                                 clk_i
   , input                               reset_i

   , input fe_cmd_s                      fe_cmd_i
   , input                               fe_cmd_v_i
   , output logic                        fe_cmd_yumi_o

   , input                               fetch_fail_i
   , input [fe_vaddr_width_lp-1:0]       fetch_pc_i

   , fe_redirect_if.decode               redir
   );

  logic                         cmd_accept;
  logic                         is_redirect;
  logic                         is_state_reset;
  logic                         is_wait;
  logic [fe_vaddr_width_lp-1:0] resume_pc_r;

  // Commands never have to wait, so each one is taken on its first valid cycle
  assign fe_cmd_yumi_o = fe_cmd_v_i;
  assign cmd_accept    = fe_cmd_v_i & fe_cmd_yumi_o;

  assign is_redirect    = (fe_cmd_i.opcode == e_op_pc_redirect);
  assign is_state_reset = (fe_cmd_i.opcode == e_op_state_reset);
  assign is_wait        = (fe_cmd_i.opcode == e_op_wait);

  assign redir.cmd_v         = cmd_accept;
  assign redir.cmd_immediate = cmd_accept & is_redirect;
  assign redir.cmd_stall     = cmd_accept & is_state_reset;
  assign redir.cmd_wait      = cmd_accept & is_wait;

  // Resume point for leaving stall
  // A state reset names it directly, a failed fetch retries its own pc
  always_ff @(posedge clk_i)
  begin
    if (redir.cmd_stall)
    begin
      resume_pc_r <= fe_cmd_i.vaddr;
    end
    else if (fetch_fail_i)
    begin
      resume_pc_r <= fetch_pc_i;
    end
  end

  assign redir.resume_pc = resume_pc_r;

  // Immediate commands bypass the resume register
  always_comb
  begin
    if (redir.cmd_immediate)
    begin
      redir.redirect_pc = fe_cmd_i.vaddr;
    end
    else
    begin
      redir.redirect_pc = resume_pc_r;
    end
  end

  // Only word aligned targets can reach the fetch path
  assert property (@(posedge clk_i) disable iff (reset_i)
    (redir.cmd_immediate || redir.cmd_stall) |-> (fe_cmd_i.vaddr[1:0] == 2'b00))
    else $error("[ERROR] %0t fe_cmd_i.vaddr unaligned: %h", $time, fe_cmd_i.vaddr);

endmodule

/* design/fe_pc_gen.sv */
// Next PC generation
module fe_pc_gen
  import fe_pkg::*;
  (input                                 clk_i
   , input                               reset_i

   , fe_redirect_if.pc_gen               redir

   , input                               next_pc_v_i
   , output logic [fe_vaddr_width_lp-1:0] next_pc_o

   , output logic [fe_vaddr_width_lp-1:0] fetch_pc_o
   );

  logic [fe_vaddr_width_lp-1:0] pc_r;
  logic [fe_vaddr_width_lp-1:0] seq_pc;

  assign seq_pc = pc_r + fe_vaddr_width_lp'(fe_pc_step_lp);

  // A redirect always wins over the sequential path
  always_comb
  begin
    if (redir.redirect_v)
    begin
      next_pc_o = redir.redirect_pc;
    end
    else
    begin
      next_pc_o = seq_pc;
    end
  end

  // Last issued pc, which is also the pc of the response one cycle later
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pc_r <= '0;
    end
    else if (next_pc_v_i)
    begin
      pc_r <= next_pc_o;
    end
  end

  assign fetch_pc_o = pc_r;

  // Issued addresses stay on word boundaries
  assert property (@(posedge clk_i) disable iff (reset_i)
    next_pc_v_i |-> (next_pc_o[1:0] == 2'b00))
    else $error("[ERROR] %0t next_pc_o unaligned: %h", $time, next_pc_o);

  // The controller only redirects in a cycle that also issues
  assert property (@(posedge clk_i) disable iff (reset_i)
    redir.redirect_v |-> next_pc_v_i)
    else $error("[ERROR] %0t redirect_v without a request issued", $time);

endmodule

/* design/fe_fetch_ctrl.sv */
// Fetch controller
module fe_fetch_ctrl
  import fe_pkg::*;
  (input                                 clk_i
   , input                               reset_i

   , fe_redirect_if.ctrl                 redir

   , input [fe_vaddr_width_lp-1:0]       fetch_pc_i
   , input [fe_instr_width_lp-1:0]       imem_data_i
   , input                               imem_fault_i

   , input                               fe_queue_ready_i

   , output logic                        next_pc_v_o
   , output logic                        fetch_fail_o

   , output fe_queue_s                   fe_queue_o
   , output logic                        fe_queue_v_o
   );

  fe_state_e state_r;
  fe_state_e state_n;

  logic fetch_v_r;
  logic poison;
  logic resp_v;
  logic exception_sent;
  logic unstall;

  // Any accepted command kills the response that is in flight
  assign poison = redir.cmd_v;
  assign resp_v = fetch_v_r & ~poison;

  // Messages only go out while the queue can take them
  assign fe_queue_v_o   = resp_v & fe_queue_ready_i;
  assign fetch_fail_o   = fetch_v_r & ~fe_queue_v_o;
  assign exception_sent = fe_queue_v_o & imem_fault_i;

  assign unstall = fe_queue_ready_i & ~redir.cmd_v;

  always_comb
  begin
    fe_queue_o    = '0;
    fe_queue_o.pc = fetch_pc_i;
    if (imem_fault_i)
    begin
      fe_queue_o.msg_type = e_fe_exception;
    end
    else
    begin
      fe_queue_o.msg_type = e_fe_fetch;
      fe_queue_o.instr    = imem_data_i;
    end
  end

  // Commands take priority over whatever the current state wants
  always_comb
  begin
    if (redir.cmd_immediate)
    begin
      state_n = e_run;
    end
    else if (redir.cmd_stall)
    begin
      state_n = e_stall;
    end
    else if (redir.cmd_wait)
    begin
      state_n = e_wait;
    end
    else
    begin
      case (state_r)
        e_stall:
        begin
          state_n = unstall ? e_run : e_stall;
        end
        e_run:
        begin
          // Failed fetch retries from stall, a sent fault parks in wait
          if (fetch_fail_o)
          begin
            state_n = e_stall;
          end
          else if (exception_sent)
          begin
            state_n = e_wait;
          end
          else
          begin
            state_n = e_run;
          end
        end
        default:
        begin
          state_n = e_wait;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= e_wait;
      fetch_v_r <= 1'b0;
    end
    else
    begin
      state_r   <= state_n;
      fetch_v_r <= next_pc_v_o;
    end
  end

  // Only run issues; a stall left without a command restarts at resume_pc
  assign next_pc_v_o      = (state_n == e_run);
  assign redir.redirect_v = redir.cmd_immediate | ((state_r == e_stall) & unstall);

  assert property (@(posedge clk_i) disable iff (reset_i)
    fe_queue_v_o |-> fe_queue_ready_i)
    else $error("[ERROR] %0t fe_queue_v_o high with ready low", $time);

endmodule

/* design/fe_top.sv */
// Instruction fetch front end
module fe_top
  import fe_pkg::*;
  (input                                  clk_i
   , input                                reset_i

   , input fe_cmd_s                       fe_cmd_i
   , input                                fe_cmd_v_i
   , output logic                         fe_cmd_yumi_o

   , output fe_queue_s                    fe_queue_o
   , output logic                         fe_queue_v_o
   , input                                fe_queue_ready_i

   , output logic                         imem_v_o
   , output logic [fe_vaddr_width_lp-1:0] imem_addr_o
   , input [fe_instr_width_lp-1:0]        imem_data_i
   , input                                imem_fault_i
   );

  logic [fe_vaddr_width_lp-1:0] next_pc_lo;
  logic [fe_vaddr_width_lp-1:0] fetch_pc_lo;
  logic                         next_pc_v_lo;
  logic                         fetch_fail_lo;

  fe_redirect_if redir ();

  fe_cmd_decode u_cmd_decode
    (.clk_i           (clk_i)
     ,.reset_i        (reset_i)
     ,.fe_cmd_i       (fe_cmd_i)
     ,.fe_cmd_v_i     (fe_cmd_v_i)
     ,.fe_cmd_yumi_o  (fe_cmd_yumi_o)
     ,.fetch_fail_i   (fetch_fail_lo)
     ,.fetch_pc_i     (fetch_pc_lo)
     ,.redir          (redir.decode)
     );

  fe_pc_gen u_pc_gen
    (.clk_i           (clk_i)
     ,.reset_i        (reset_i)
     ,.redir          (redir.pc_gen)
     ,.next_pc_v_i    (next_pc_v_lo)
     ,.next_pc_o      (next_pc_lo)
     ,.fetch_pc_o     (fetch_pc_lo)
     );

  fe_fetch_ctrl u_fetch_ctrl
    (.clk_i             (clk_i)
     ,.reset_i          (reset_i)
     ,.redir            (redir.ctrl)
     ,.fetch_pc_i       (fetch_pc_lo)
     ,.imem_data_i      (imem_data_i)
     ,.imem_fault_i     (imem_fault_i)
     ,.fe_queue_ready_i (fe_queue_ready_i)
     ,.next_pc_v_o      (next_pc_v_lo)
     ,.fetch_fail_o     (fetch_fail_lo)
     ,.fe_queue_o       (fe_queue_o)
     ,.fe_queue_v_o     (fe_queue_v_o)
     );

  // Memory request is the issued pc
  assign imem_v_o    = next_pc_v_lo;
  assign imem_addr_o = next_pc_lo;

endmodule

/* dv/fe_tb.sv */
// Fetch front end testbench
module fe_tb
  import fe_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [fe_vaddr_width_lp-1:0] scramble_lp   = 32'h5a5a_0000;
  localparam logic [fe_vaddr_width_lp-1:0] fault_base_lp = 32'h0000_4000;
  localparam int fault_words_lp  = 4;
  localparam int num_phases_lp   = 6;
  localparam int phase_cycles_lp = 400;
  localparam int wait_limit_lp   = 200;

  logic                         clk;
  logic                         reset;
  fe_cmd_s                      fe_cmd;
  logic                         fe_cmd_v;
  logic                         fe_cmd_yumi;
  fe_queue_s                    fe_queue;
  logic                         fe_queue_v;
  logic                         fe_queue_ready;
  logic                         imem_v;
  logic [fe_vaddr_width_lp-1:0] imem_addr;
  logic [fe_instr_width_lp-1:0] imem_data;
  logic                         imem_fault;

  logic                         cmd_fire;
  logic                         ready_random;
  integer                       seed;

  // Scoreboard state
  logic [fe_vaddr_width_lp-1:0] exp_pc;
  logic                         expect_msg;
  logic                         parked;

  fe_top u_dut
    (.clk_i             (clk)
     ,.reset_i          (reset)
     ,.fe_cmd_i         (fe_cmd)
     ,.fe_cmd_v_i       (fe_cmd_v)
     ,.fe_cmd_yumi_o    (fe_cmd_yumi)
     ,.fe_queue_o       (fe_queue)
     ,.fe_queue_v_o     (fe_queue_v)
     ,.fe_queue_ready_i (fe_queue_ready)
     ,.imem_v_o         (imem_v)
     ,.imem_addr_o      (imem_addr)
     ,.imem_data_i      (imem_data)
     ,.imem_fault_i     (imem_fault)
     );

  assign cmd_fire = fe_cmd_v & fe_cmd_yumi;

  always #2 clk = ~clk;

  task automatic end_with_failure(input string line);
    $display("%s", line);
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic logic in_fault_window(input logic [fe_vaddr_width_lp-1:0] addr);
    return (addr >= fault_base_lp)
      && (addr < fault_base_lp + fe_vaddr_width_lp'(fault_words_lp * fe_pc_step_lp));
  endfunction

  // Exceptions carry a zero instruction
  function automatic logic [fe_instr_width_lp-1:0] expected_instr
    (input logic [fe_vaddr_width_lp-1:0] pc);
    if (in_fault_window(pc))
    begin
      return '0;
    end
    else
    begin
      return pc ^ scramble_lp;
    end
  endfunction

  // Memory answers one cycle after the request
  always @(posedge clk)
  begin
    if (imem_v)
    begin
      imem_data  <= imem_addr ^ scramble_lp;
      imem_fault <= in_fault_window(imem_addr);
    end
    else
    begin
      imem_fault <= 1'b0;
    end
  end

  always @(posedge clk)
  begin
    if (ready_random)
    begin
      fe_queue_ready <= (($random(seed) % 4) != 0);
    end
    else
    begin
      fe_queue_ready <= 1'b1;
    end
  end

  // Out of reset the front end idles as if it had taken a wait
  always @(posedge clk)
  begin
    if (reset)
    begin
      exp_pc     <= '0;
      expect_msg <= 1'b0;
      parked     <= 1'b1;
    end
    else if (cmd_fire)
    begin
      if (fe_cmd.opcode != e_op_wait)
      begin
        exp_pc <= fe_cmd.vaddr;
      end
      expect_msg <= (fe_cmd.opcode == e_op_pc_redirect);
      parked     <= (fe_cmd.opcode == e_op_wait);
    end
    else if (fe_queue_v)
    begin
      exp_pc     <= fe_queue.pc + fe_vaddr_width_lp'(fe_pc_step_lp);
      expect_msg <= (fe_queue.msg_type == e_fe_fetch);
      parked     <= (fe_queue.msg_type == e_fe_exception);
    end
    else
    begin
      expect_msg <= 1'b0;
    end
  end

  cmd_accept_check: assert property (@(posedge clk) disable iff (reset)
    fe_cmd_yumi == fe_cmd_v)
    else end_with_failure($sformatf("[ERROR] %0t fe_cmd_yumi_o expected %b actual %b",
      $time, $sampled(fe_cmd_v), $sampled(fe_cmd_yumi)));

  // An accepted command drops the message of its own cycle
  cmd_poison_check: assert property (@(posedge clk) disable iff (reset)
    cmd_fire |-> !fe_queue_v)
    else end_with_failure($sformatf(
      "[ERROR] %0t fe_queue_v_o expected 0 actual 1, command accepted", $time));

  queue_ready_check: assert property (@(posedge clk) disable iff (reset)
    fe_queue_v |-> fe_queue_ready)
    else end_with_failure($sformatf("[ERROR] %0t fe_queue_v_o expected 0 actual 1, ready low",
      $time));

  queue_pc_check: assert property (@(posedge clk) disable iff (reset)
    fe_queue_v |-> (fe_queue.pc == exp_pc))
    else end_with_failure($sformatf("[ERROR] %0t fe_queue_o.pc expected %h actual %h",
      $time, $sampled(exp_pc), $sampled(fe_queue.pc)));

  queue_kind_check: assert property (@(posedge clk) disable iff (reset)
    fe_queue_v |-> ((fe_queue.msg_type == e_fe_exception) == in_fault_window(fe_queue.pc)))
    else end_with_failure($sformatf("[ERROR] %0t fe_queue_o.msg_type expected %0d actual %0d",
      $time, in_fault_window($sampled(fe_queue.pc)), $sampled(fe_queue.msg_type)));

  queue_instr_check: assert property (@(posedge clk) disable iff (reset)
    fe_queue_v |-> (fe_queue.instr == expected_instr(fe_queue.pc)))
    else end_with_failure($sformatf("[ERROR] %0t fe_queue_o.instr expected %h actual %h",
      $time, expected_instr($sampled(fe_queue.pc)), $sampled(fe_queue.instr)));

  // A redirect or a sent fetch keeps the stream going while ready stays high
  stream_check: assert property (@(posedge clk) disable iff (reset)
    (expect_msg && fe_queue_ready && !fe_cmd_v) |-> fe_queue_v)
    else end_with_failure($sformatf("[ERROR] %0t fe_queue_v_o expected 1 actual 0", $time));

  idle_check: assert property (@(posedge clk) disable iff (reset)
    (parked && !cmd_fire) |-> (!imem_v && !fe_queue_v))
    else end_with_failure($sformatf(
      "[ERROR] %0t imem_v_o/fe_queue_v_o expected 0/0 actual %b/%b in state %s",
      $time, $sampled(imem_v), $sampled(fe_queue_v), u_dut.u_fetch_ctrl.state_r.name()));

  task automatic send_cmd(input fe_opcode_e op, input logic [fe_vaddr_width_lp-1:0] addr);
    int cycles;
    cycles = 0;
    fe_cmd.opcode <= op;
    fe_cmd.vaddr  <= addr;
    fe_cmd_v      <= 1'b1;
    do
    begin
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit_lp)
      begin
        end_with_failure($sformatf("Command %s was never accepted, gave up at %0t",
          op.name(), $time));
      end
    end
    while (!fe_cmd_yumi);
    fe_cmd_v <= 1'b0;
  endtask

  task automatic wait_for_msgs(input int count);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < count)
    begin
      @(posedge clk);
      cycles++;
      if (fe_queue_v)
      begin
        seen++;
      end
      if (cycles > wait_limit_lp)
      begin
        end_with_failure($sformatf("Only %0d of %0d queue messages arrived by %0t",
          seen, count, $time));
      end
    end
  endtask

  task automatic wait_for_exception();
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit_lp)
      begin
        end_with_failure($sformatf("No exception message arrived by %0t", $time));
      end
    end
    while (!(fe_queue_v && (fe_queue.msg_type == e_fe_exception)));
  endtask

  initial
  begin
    repeat (num_phases_lp * phase_cycles_lp) @(posedge clk);
    end_with_failure($sformatf("Watchdog expired at %0t before the tests finished", $time));
  end

  initial
  begin
    clk            = 1'b0;
    reset          = 1'b1;
    fe_cmd         = '0;
    fe_cmd_v       = 1'b0;
    fe_queue_ready = 1'b1;
    imem_data      = '0;
    imem_fault     = 1'b0;
    ready_random   = 1'b0;
    seed           = 32'hc0a;

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (20) @(posedge clk);

    // Straight run with ready held high
    send_cmd(e_op_pc_redirect, 32'h0000_1000);
    wait_for_msgs(16);

    ready_random <= 1'b1;
    wait_for_msgs(64);

    // Restart from a state reset under back-pressure
    send_cmd(e_op_state_reset, 32'h0000_2000);
    wait_for_msgs(8);

    // Walk into the fault window
    ready_random <= 1'b0;
    send_cmd(e_op_pc_redirect, fault_base_lp - 32'd8);
    wait_for_exception();
    repeat (20) @(posedge clk);

    send_cmd(e_op_pc_redirect, 32'h0000_3000);
    wait_for_msgs(8);
    send_cmd(e_op_wait, 32'h0000_0000);
    repeat (20) @(posedge clk);

    $display("TB PASSED");
    $finish;
  end

endmodule

/* list.f */
design/fe_pkg.sv
design/fe_redirect_if.sv
design/fe_cmd_decode.sv
design/fe_pc_gen.sv
design/fe_fetch_ctrl.sv
design/fe_top.sv
dv/fe_tb.sv
